// File: fft_butterfly.f
+incdir+include
verilog/butterfly_pkg.sv
verilog/pipelined_mpy.sv
verilog/karatsuba_cmpy.sv
verilog/butterfly_addsub.sv
verilog/sum_delay_ram.sv
verilog/conv_round.sv
verilog/butterfly_top.sv
testbench/butterfly_tb.sv

// File: include/butterfly_ref.svh
/* Testbench reference model; include inside a scope that imports butterfly_pkg.
   Matches the hardware for SHIFT of 0 and coefficient parts within 2**(COEF_W-2) */
`ifndef BUTTERFLY_REF_SVH
`define BUTTERFLY_REF_SVH

// Expected pair for one input sample
typedef struct packed {
    out_cplx_t left;
    out_cplx_t right;
} bfly_expect_t;

// Divide by coefficient unity, round half to even, wrap to OUT_W
function automatic out_part_t ref_round(input longint val);
    longint unit;
    longint q;
    longint frac;
    unit = longint'(1) << (COEF_W - 2);
    // Arithmetic shift floors, so frac is never negative
    q    = val >>> (COEF_W - 2);
    frac = val - (q << (COEF_W - 2));
    if (frac > unit / 2)
        q = q + 1;
    else if (frac == unit / 2)
        q = q + (q & 1);
    return out_part_t'(q);
endfunction

// L' = L + R, exact in OUT_W bits
function automatic out_cplx_t ref_left(input in_cplx_t l, input in_cplx_t r);
    out_cplx_t res;
    res.re = out_part_t'(longint'(l.re) + longint'(r.re));
    res.im = out_part_t'(longint'(l.im) + longint'(r.im));
    return res;
endfunction

// R' = (L - R) * C, plain four-product form
function automatic out_cplx_t ref_right(input in_cplx_t l, input in_cplx_t r,
                                        input coef_cplx_t c);
    longint    d_re;
    longint    d_im;
    out_cplx_t res;
    d_re   = longint'(l.re) - longint'(r.re);
    d_im   = longint'(l.im) - longint'(r.im);
    res.re = ref_round(d_re * longint'(c.re) - d_im * longint'(c.im));
    res.im = ref_round(d_re * longint'(c.im) + d_im * longint'(c.re));
    return res;
endfunction

// Both outputs for one sample
function automatic bfly_expect_t ref_butterfly(input in_cplx_t l, input in_cplx_t r,
                                               input coef_cplx_t c);
    bfly_expect_t res;
    res.left  = ref_left(l, r);
    res.right = ref_right(l, r, c);
    return res;
endfunction

`endif

// File: testbench/butterfly_tb.sv
/* Self-checking testbench for butterfly_top with SHIFT 0. Coefficient parts stay
   within 2**(COEF_W-2), so the reference model in butterfly_ref.svh applies */
`timescale 1ns/10ps

module butterfly_tb
    import butterfly_pkg::*;
();

    `include "butterfly_ref.svh"

    // ==============================
    // Run length and limits
    // ==============================
    localparam int SEED         = 59839;
    localparam int RESET_CYCLES = 5;
    localparam int COEF_UNIT    = 1 << (COEF_W - 2);
    localparam int COEF_HALF    = COEF_UNIT / 2;
    localparam int N_SUM        = 6;
    localparam int N_ROT        = 8;
    localparam int N_RND        = 10;
    localparam int N_RAND       = 300;
    localparam int N_GAP        = 150;
    localparam int N_SYNC       = 40;
    localparam int MAX_GAP      = 4;
    localparam int N_TESTS      = 6;
    // Worst case has every sample preceded by a full gap and a drain per test
    localparam int STIM_CYCLES  = RESET_CYCLES + N_SUM + N_ROT + N_RND + N_RAND
                                + (N_GAP + N_SYNC) * (1 + MAX_GAP)
                                + N_TESTS * (BFLY_LATENCY + 2);
    localparam int TIMEOUT      = 2 * STIM_CYCLES + 100;

    // Expected result waiting for its output slot
    typedef struct packed {
        bfly_expect_t want;
        logic         aux;
        int           idx;
    } pending_t;

    logic       i_clk = 1'b0;
    logic       i_reset;
    logic       i_ce;
    in_cplx_t   i_left;
    in_cplx_t   i_right;
    coef_cplx_t i_coef;
    logic       i_aux;
    out_cplx_t  o_left;
    out_cplx_t  o_right;
    logic       o_aux;

    // Marks a driven sample as one to be checked
    logic       sample_valid;
    pending_t   exp_q[$];
    int         en_count;
    logic       edge_enabled;
    int         cycle_count;
    int         err_count;
    int         check_count;
    int         test_err_base;
    int         test_chk_base;
    string      test_name;

    // Outputs seen at the previous falling edge
    out_cplx_t  held_left;
    out_cplx_t  held_right;
    logic       held_aux;

    butterfly_top #(.SHIFT(0)) DUT (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ce    (i_ce),
        .i_left  (i_left),
        .i_right (i_right),
        .i_coef  (i_coef),
        .i_aux   (i_aux),
        .o_left  (o_left),
        .o_right (o_right),
        .o_aux   (o_aux)
    );

    always #50 i_clk = ~i_clk;

    // ==============================
    // Stimulus helpers
    // ==============================
    function automatic in_cplx_t make_in(input int re, input int im);
        in_cplx_t v;
        v.re = in_part_t'(re);
        v.im = in_part_t'(im);
        return v;
    endfunction

    function automatic coef_cplx_t make_coef(input int re, input int im);
        coef_cplx_t v;
        v.re = coef_part_t'(re);
        v.im = coef_part_t'(im);
        return v;
    endfunction

    function automatic in_cplx_t random_in();
        return make_in(int'(in_part_t'($urandom)), int'(in_part_t'($urandom)));
    endfunction

    // Parts limited to plus or minus coefficient unity
    function automatic coef_cplx_t random_coef();
        int re;
        int im;
        re = int'($urandom_range(2 * COEF_UNIT, 0)) - COEF_UNIT;
        im = int'($urandom_range(2 * COEF_UNIT, 0)) - COEF_UNIT;
        return make_coef(re, im);
    endfunction

    // One enabled cycle carrying a checked sample
    task automatic drive_sample(input in_cplx_t l, input in_cplx_t r,
                                input coef_cplx_t c, input logic aux);
        @(posedge i_clk);
        #1;
        i_ce         = 1'b1;
        sample_valid = 1'b1;
        i_left       = l;
        i_right      = r;
        i_coef       = c;
        i_aux        = aux;
    endtask

    // Enable low with scrambled inputs that the DUT must ignore
    task automatic drive_gap(input int unsigned n);
        repeat (n)
        begin
            @(posedge i_clk);
            #1;
            i_ce         = 1'b0;
            sample_valid = 1'b0;
            i_left       = random_in();
            i_right      = random_in();
            i_coef       = random_coef();
            i_aux        = $urandom_range(1, 0);
        end
    endtask

    task automatic idle_cycle();
        @(posedge i_clk);
        #1;
        i_ce         = 1'b1;
        sample_valid = 1'b0;
        i_left       = '0;
        i_right      = '0;
        i_coef       = '0;
        i_aux        = 1'b0;
    endtask

    // First idle edge captures the last driven sample
    task automatic drain_pipeline();
        idle_cycle();
        while (exp_q.size() != 0)
            idle_cycle();
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = err_count;
        test_chk_base = check_count;
    endtask

    task automatic finish_test();
        $display("%s: %0d checks, %0d errors", test_name,
                 check_count - test_chk_base, err_count - test_err_base);
    endtask

    // ==============================
    // Capture of expected values
    // ==============================
    always @(posedge i_clk)
    begin : capture_proc
        pending_t entry;
        if (i_reset)
        begin
            en_count     = 0;
            edge_enabled = 1'b0;
        end
        else
        begin
            edge_enabled = i_ce;
            if (i_ce)
            begin
                if (sample_valid)
                begin
                    entry.want = ref_butterfly(i_left, i_right, i_coef);
                    entry.aux  = i_aux;
                    entry.idx  = en_count;
                    exp_q.push_back(entry);
                end
                en_count++;
            end
        end
    end

    // ==============================
    // Comparison at the falling edge
    // ==============================
    always @(negedge i_clk)
    begin : check_proc
        pending_t head;
        if (!i_reset)
        begin
            check_count++;
            if (!edge_enabled)
            begin
                // Outputs hold through a gap
                assert (o_left === held_left && o_right === held_right && o_aux === held_aux)
                else
                begin
                    $display("Fail at %0t: outputs changed while i_ce was low", $time);
                    err_count++;
                end
            end
            else if (exp_q.size() != 0 && en_count - exp_q[0].idx >= BFLY_LATENCY)
            begin
                head = exp_q.pop_front();
                assert (o_left === head.want.left)
                else
                begin
                    $display("Fail at %0t: sample %0d o_left %h expected %h",
                             $time, head.idx, o_left, head.want.left);
                    err_count++;
                end
                assert (o_right === head.want.right)
                else
                begin
                    $display("Fail at %0t: sample %0d o_right %h expected %h",
                             $time, head.idx, o_right, head.want.right);
                    err_count++;
                end
                assert (o_aux === head.aux)
                else
                begin
                    $display("Fail at %0t: sample %0d o_aux %b expected %b",
                             $time, head.idx, o_aux, head.aux);
                    err_count++;
                end
            end
            else
            begin
                // No sync pulse when nothing is due
                assert (o_aux === 1'b0)
                else
                begin
                    $display("Fail at %0t: o_aux high with no sample due", $time);
                    err_count++;
                end
            end
        end
        held_left  = o_left;
        held_right = o_right;
        held_aux   = o_aux;
    end

    // Run limit
    always @(posedge i_clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT)
        begin
            $display("Timeout: run still going after %0d clock cycles", TIMEOUT);
            $display("Errors found");
            $finish;
        end
    end

    // ==============================
    // Test sequence
    // ==============================
    initial
    begin : main_proc
        i_reset      = 1'b1;
        i_ce         = 1'b0;
        i_left       = '0;
        i_right      = '0;
        i_coef       = '0;
        i_aux        = 1'b0;
        sample_valid = 1'b0;
        cycle_count  = 0;
        err_count    = 0;
        check_count  = 0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        // Zero coefficient with full-scale sums
        start_test("sum path");
        check_count++;
        assert (o_aux === 1'b0)
        else
        begin
            $display("Reset failed to clear o_aux");
            err_count++;
        end
        drive_sample(make_in(100, -200), make_in(300, 400), make_coef(0, 0), 1'b0);
        drive_sample(make_in(32767, 32767), make_in(32767, 32767), make_coef(0, 0), 1'b0);
        drive_sample(make_in(-32768, -32768), make_in(-32768, -32768), make_coef(0, 0), 1'b0);
        drive_sample(make_in(32767, -32768), make_in(-32768, 32767), make_coef(0, 0), 1'b0);
        drive_sample(make_in(-1, 1), make_in(1, -1), make_coef(0, 0), 1'b0);
        drive_sample(make_in(12345, -54), make_in(-7, 9999), make_coef(0, 0), 1'b0);
        drain_pipeline();
        finish_test();

        // Unity and j twiddles
        start_test("rotation");
        drive_sample(make_in(1000, -2000), make_in(-300, 40), make_coef(COEF_UNIT, 0), 1'b0);
        drive_sample(make_in(32767, 32767), make_in(-32768, -32768), make_coef(COEF_UNIT, 0), 1'b0);
        drive_sample(make_in(-32768, 5), make_in(32767, -5), make_coef(COEF_UNIT, 0), 1'b0);
        drive_sample(make_in(0, 0), make_in(1, -1), make_coef(COEF_UNIT, 0), 1'b0);
        drive_sample(make_in(1000, -2000), make_in(-300, 40), make_coef(0, COEF_UNIT), 1'b0);
        drive_sample(make_in(32767, 32767), make_in(-32768, -32768), make_coef(0, COEF_UNIT), 1'b0);
        drive_sample(make_in(-32768, 5), make_in(32767, -5), make_coef(0, COEF_UNIT), 1'b0);
        drive_sample(make_in(0, 0), make_in(1, -1), make_coef(0, COEF_UNIT), 1'b0);
        drain_pipeline();
        finish_test();

        // Half twiddle on odd differences lands exactly on halves
        start_test("rounding");
        drive_sample(make_in(1, 0), make_in(0, 0), make_coef(COEF_HALF, 0), 1'b0);
        drive_sample(make_in(3, 0), make_in(0, 0), make_coef(COEF_HALF, 0), 1'b0);
        drive_sample(make_in(-1, 0), make_in(0, 0), make_coef(COEF_HALF, 0), 1'b0);
        drive_sample(make_in(-3, 0), make_in(0, 0), make_coef(COEF_HALF, 0), 1'b0);
        drive_sample(make_in(5, 0), make_in(0, 0), make_coef(COEF_HALF, 0), 1'b0);
        drive_sample(make_in(0, 7), make_in(0, 0), make_coef(0, COEF_HALF), 1'b0);
        drive_sample(make_in(9, -11), make_in(0, 0), make_coef(0, COEF_HALF), 1'b0);
        drive_sample(make_in(-5, 2), make_in(0, 0), make_coef(COEF_HALF, COEF_HALF), 1'b0);
        drive_sample(make_in(2, 0), make_in(0, 0), make_coef(COEF_UNIT / 4, 0), 1'b0);
        drive_sample(make_in(6, 0), make_in(0, 0), make_coef(COEF_UNIT / 4, 0), 1'b0);
        drain_pipeline();
        finish_test();

        start_test("random stream");
        repeat (N_RAND)
            drive_sample(random_in(), random_in(), random_coef(), $urandom_range(7, 0) == 0);
        drain_pipeline();
        finish_test();

        // Random enable gaps between samples
        start_test("enable gaps");
        repeat (N_GAP)
        begin
            if ($urandom_range(2, 0) == 0)
                drive_gap($urandom_range(MAX_GAP, 1));
            drive_sample(random_in(), random_in(), random_coef(), $urandom_range(7, 0) == 0);
        end
        drain_pipeline();
        finish_test();

        // Regular sync pulses with gaps in between
        start_test("sync");
        for (int i = 0; i < N_SYNC; i++)
        begin
            if (i % 3 == 1)
                drive_gap($urandom_range(MAX_GAP, 1));
            drive_sample(random_in(), random_in(), random_coef(), i % 5 == 0);
        end
        drain_pipeline();
        finish_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", N_TESTS, check_count, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: verilog/butterfly_top.sv
/* Full-rate DIF butterfly, one sample per enabled clock and no back-pressure.
   Results and o_aux appear BFLY_LATENCY enabled cycles after their inputs */
`timescale 1ns/10ps

module butterfly_top
    import butterfly_pkg::*;
#(
    // Extra right shift on top of the fixed scaling
    parameter int SHIFT = 0
) (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_ce,
    input  in_cplx_t   i_left,
    input  in_cplx_t   i_right,
    input  coef_cplx_t i_coef,
    input  logic       i_aux,
    output out_cplx_t  o_left,
    output out_cplx_t  o_right,
    output logic       o_aux
);

    // Add/sub results and coefficient aligned with the difference
    sum_cplx_t  sum;
    sum_cplx_t  dif;
    coef_cplx_t coef_d;

    // Rotated difference and delayed sum, both on the product scale
    wide_t      mpy_re;
    wide_t      mpy_im;
    wide_t      sum_re;
    wide_t      sum_im;

    // Rounded parts
    out_part_t  rnd_left_re;
    out_part_t  rnd_left_im;
    out_part_t  rnd_right_re;
    out_part_t  rnd_right_im;

    // Sync delay, one bit short of the latency, the last bit is o_aux
    logic [BFLY_LATENCY-2:0] aux_sr;

    // ==============================
    // Datapath
    // ==============================
    butterfly_addsub u_addsub (
        .i_clk   (i_clk),
        .i_ce    (i_ce),
        .i_left  (i_left),
        .i_right (i_right),
        .i_coef  (i_coef),
        .o_sum   (sum),
        .o_dif   (dif),
        .o_coef  (coef_d)
    );

    // Difference path, (L-R)*C
    karatsuba_cmpy #(.MPY_STAGES(MPY_DELAY)) u_cmpy (
        .i_clk  (i_clk),
        .i_ce   (i_ce),
        .i_dif  (dif),
        .i_coef (coef_d),
        .o_re   (mpy_re),
        .o_im   (mpy_im)
    );

    // Sum path waits out the multiplier
    sum_delay_ram #(.DELAY(MPY_DELAY), .DEPTH_LG(DELAY_LG)) u_sum_dly (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_ce    (i_ce),
        .i_sum   (sum),
        .o_re    (sum_re),
        .o_im    (sum_im)
    );

    // Top four bits of the wide values carry only growth and sign
    conv_round #(.DROP_TOP(SHIFT + 4)) u_rnd_left_re (
        .i_clk(i_clk), .i_ce(i_ce), .i_val(sum_re), .o_val(rnd_left_re)
    );
    conv_round #(.DROP_TOP(SHIFT + 4)) u_rnd_left_im (
        .i_clk(i_clk), .i_ce(i_ce), .i_val(sum_im), .o_val(rnd_left_im)
    );
    conv_round #(.DROP_TOP(SHIFT + 4)) u_rnd_right_re (
        .i_clk(i_clk), .i_ce(i_ce), .i_val(mpy_re), .o_val(rnd_right_re)
    );
    conv_round #(.DROP_TOP(SHIFT + 4)) u_rnd_right_im (
        .i_clk(i_clk), .i_ce(i_ce), .i_val(mpy_im), .o_val(rnd_right_im)
    );

    assign o_left  = '{re: rnd_left_re, im: rnd_left_im};
    assign o_right = '{re: rnd_right_re, im: rnd_right_im};

    // ==============================
    // Sync line
    // ==============================
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            aux_sr <= '0;
            o_aux  <= 1'b0;
        end
        else if (i_ce)
        begin
            aux_sr <= {aux_sr[BFLY_LATENCY-3:0], i_aux};
            o_aux  <= aux_sr[BFLY_LATENCY-2];
        end
    end

endmodule

// File: verilog/conv_round.sv
/* Registered round half to even of one wide value down to OUT_W bits.
   Discarded top bits are assumed to be sign only, overflow wraps */
`timescale 1ns/10ps

module conv_round
    import butterfly_pkg::*;
#(
    // Top bits thrown away above the kept field
    parameter int DROP_TOP = 4
) (
    input  logic      i_clk,
    input  logic      i_ce,
    input  wide_t     i_val,
    output out_part_t o_val
);

    // Bits rounded off below the kept field, at least two
    localparam int LOW_W = WIDE_W - DROP_TOP - OUT_W;

    out_part_t kept;
    logic      half_bit;
    logic      sticky;
    logic      round_up;

    // Kept field sits just under the dropped top bits
    assign kept     = i_val[WIDE_W-DROP_TOP-1 -: OUT_W];

    // First lost bit weighs one half
    assign half_bit = i_val[LOW_W-1];
    // Any lower bit set means above half
    assign sticky   = |i_val[LOW_W-2:0];

    // Exact halves go to the even neighbour
    assign round_up = half_bit & (sticky | kept[0]);

    always_ff @(posedge i_clk)
    begin
        if (i_ce)
            o_val <= kept + round_up;
    end

endmodule

// File: verilog/sum_delay_ram.sv
/* Circular delay of DELAY enabled cycles plus one read register for the sum.
   DELAY must stay below 2**DEPTH_LG. Output is scaled to the product range */
`timescale 1ns/10ps

module sum_delay_ram
    import butterfly_pkg::*;
#(
    parameter int DELAY    = 11,
    parameter int DEPTH_LG = 4
) (
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_ce,
    input  sum_cplx_t i_sum,
    output wide_t     o_re,
    output wide_t     o_im
);

    // Zero padding matches the 2**(COEF_W-2) coefficient unity
    localparam int PAD_W = COEF_W - 2;
    localparam int EXT_W = WIDE_W - SUM_W - PAD_W;

    sum_cplx_t             mem [2**DEPTH_LG];
    logic [DEPTH_LG-1:0]   wr_ptr;
    logic [DEPTH_LG-1:0]   rd_addr;
    sum_cplx_t             rd_q;

    // Read pointer trails the write pointer, wraps naturally
    assign rd_addr = wr_ptr - DEPTH_LG'(DELAY);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            wr_ptr <= '0;
        else if (i_ce)
            wr_ptr <= wr_ptr + 1'b1;
    end

    // Write and read share the enable, so gaps keep the alignment
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            mem[wr_ptr] <= i_sum;
            rd_q        <= mem[rd_addr];
        end
    end

    assign o_re = {{EXT_W{rd_q.re[SUM_W-1]}}, rd_q.re, {PAD_W{1'b0}}};
    assign o_im = {{EXT_W{rd_q.im[SUM_W-1]}}, rd_q.im, {PAD_W{1'b0}}};

endmodule

// File: verilog/butterfly_addsub.sv
/* Two enabled stages: input capture, then L+R and L-R with one bit of growth.
   The coefficient is delayed to arrive with the difference */
`timescale 1ns/10ps

module butterfly_addsub
    import butterfly_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_ce,
    input  in_cplx_t   i_left,
    input  in_cplx_t   i_right,
    input  coef_cplx_t i_coef,
    output sum_cplx_t  o_sum,
    output sum_cplx_t  o_dif,
    output coef_cplx_t o_coef
);

    // Stage 1 registers
    in_cplx_t   left_q;
    in_cplx_t   right_q;
    coef_cplx_t coef_q;

    // Stage 1, isolate the inputs from outside routing
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            left_q  <= i_left;
            right_q <= i_right;
            coef_q  <= i_coef;
        end
    end

    // Stage 2, signed parts widen to SUM_W before the add
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            o_sum.re <= left_q.re + right_q.re;
            o_sum.im <= left_q.im + right_q.im;
            o_dif.re <= left_q.re - right_q.re;
            o_dif.im <= left_q.im - right_q.im;
            // Second coefficient register, lines up with o_dif
            o_coef   <= coef_q;
        end
    end

endmodule

// File: verilog/karatsuba_cmpy.sv
/* Three-multiplier complex product (a+jb)(c+jd), latency MPY_STAGES+1 enabled
   cycles. Products keep the full width, scaling is left to the rounders */
`timescale 1ns/10ps

module karatsuba_cmpy
    import butterfly_pkg::*;
#(
    parameter int MPY_STAGES = 11
) (
    input  logic       i_clk,
    input  logic       i_ce,
    input  sum_cplx_t  i_dif,
    input  coef_cplx_t i_coef,
    output wide_t      o_re,
    output wide_t      o_im
);

    // Karatsuba form, with a+jb the difference and c+jd the twiddle
    //   P1 = a*c
    //   P2 = b*d
    //   P3 = (a+b)*(c+d)
    //   re = P1 - P2
    //   im = P3 - P1 - P2 = a*d + b*c

    // Operands on the coefficient side
    logic signed [MPY_A_W-1:0] c_re_x;
    logic signed [MPY_A_W-1:0] c_im_x;
    logic signed [MPY_A_W-1:0] c_sum;

    // Operands on the data side
    logic signed [MPY_B_W-1:0] d_re_x;
    logic signed [MPY_B_W-1:0] d_im_x;
    logic signed [MPY_B_W-1:0] d_sum;

    // Partial products
    logic signed [PROD_W-1:0]  p_one;
    logic signed [PROD_W-1:0]  p_two;
    logic signed [PROD_W-1:0]  p_three;

    // ==============================
    // Operand preparation
    // ==============================
    // Sign extension by one bit so P1 and P2 match the P3 operand widths
    assign c_re_x = i_coef.re;
    assign c_im_x = i_coef.im;
    assign d_re_x = i_dif.re;
    assign d_im_x = i_dif.im;

    // Pre-adders for P3, growth absorbed by the padded width
    assign c_sum = i_coef.re + i_coef.im;
    assign d_sum = i_dif.re + i_dif.im;

    // ==============================
    // Multipliers
    // ==============================
    // Equal widths give equal depth, so the three products stay aligned
    pipelined_mpy #(.A_W(MPY_A_W), .B_W(MPY_B_W), .STAGES(MPY_STAGES)) u_p1 (
        .i_clk (i_clk),
        .i_ce  (i_ce),
        .i_a   (c_re_x),
        .i_b   (d_re_x),
        .o_p   (p_one)
    );

    pipelined_mpy #(.A_W(MPY_A_W), .B_W(MPY_B_W), .STAGES(MPY_STAGES)) u_p2 (
        .i_clk (i_clk),
        .i_ce  (i_ce),
        .i_a   (c_im_x),
        .i_b   (d_im_x),
        .o_p   (p_two)
    );

    pipelined_mpy #(.A_W(MPY_A_W), .B_W(MPY_B_W), .STAGES(MPY_STAGES)) u_p3 (
        .i_clk (i_clk),
        .i_ce  (i_ce),
        .i_a   (c_sum),
        .i_b   (d_sum),
        .o_p   (p_three)
    );

    // ==============================
    // Reconstruction
    // ==============================
    // Intermediate P3 terms may wrap, the final imaginary part fits
    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            o_re <= p_one - p_two;
            o_im <= p_three - p_one - p_two;
        end
    end

endmodule

// File: verilog/pipelined_mpy.sv
/* Signed multiplier, exactly STAGES enabled cycles from operands to product.
   STAGES must be at least 2. One new product per enabled cycle */
`timescale 1ns/10ps

module pipelined_mpy #(
    parameter int A_W    = 21,
    parameter int B_W    = 18,
    parameter int STAGES = 11
) (
    input  logic                      i_clk,
    input  logic                      i_ce,
    input  logic signed [A_W-1:0]     i_a,
    input  logic signed [B_W-1:0]     i_b,
    output logic signed [A_W+B_W-1:0] o_p
);

    localparam int P_W = A_W + B_W;

    // Operand registers, first stage
    logic signed [A_W-1:0] a_q;
    logic signed [B_W-1:0] b_q;
    logic signed [P_W-1:0] prod;

    // Remaining STAGES-1 product registers, free for retiming into the array
    logic signed [P_W-1:0] pipe [STAGES-1];

    assign prod = a_q * b_q;

    always_ff @(posedge i_clk)
    begin
        if (i_ce)
        begin
            a_q     <= i_a;
            b_q     <= i_b;
            pipe[0] <= prod;
            for (int i = 1; i < STAGES - 1; i++)
            begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // Last register of the chain
    assign o_p = pipe[STAGES-2];

endmodule

// File: verilog/butterfly_pkg.sv
/* Widths are fixed here and the pipeline depths follow from them.
   Coefficient unity is 2**(COEF_W-2). Real part sits above the imaginary part */
package butterfly_pkg;

    // ==============================
    // Data widths
    // ==============================
    localparam int IN_W    = 16;
    localparam int COEF_W  = 20;
    localparam int OUT_W   = 17;
    // One bit of growth from L+R and L-R
    localparam int SUM_W   = IN_W + 1;

    // Multiplier operands, padded so that P1, P2 and P3 share one shape
    localparam int MPY_A_W = COEF_W + 1;
    localparam int MPY_B_W = SUM_W + 1;
    localparam int PROD_W  = MPY_A_W + MPY_B_W;
    localparam int WIDE_W  = PROD_W;

    // ==============================
    // Latency
    // ==============================
    // Roughly one stage per two bits of the narrower operand, plus overhead
    localparam int MPY_NARROW   = (MPY_B_W < MPY_A_W) ? MPY_B_W : MPY_A_W;
    localparam int MPY_DELAY    = MPY_NARROW / 2 + 2;
    localparam int DELAY_LG     = $clog2(MPY_DELAY + 1);
    // Input reg, add/sub, multiplier, reconstruction, rounding
    localparam int BFLY_LATENCY = 2 + MPY_DELAY + 1 + 1;

    // Scalar parts
    typedef logic signed [IN_W-1:0]   in_part_t;
    typedef logic signed [COEF_W-1:0] coef_part_t;
    typedef logic signed [SUM_W-1:0]  sum_part_t;
    typedef logic signed [OUT_W-1:0]  out_part_t;
    typedef logic signed [WIDE_W-1:0] wide_t;

    // Complex samples, real in the upper half
    typedef struct packed {
        in_part_t re;
        in_part_t im;
    } in_cplx_t;

    typedef struct packed {
        coef_part_t re;
        coef_part_t im;
    } coef_cplx_t;

    typedef struct packed {
        sum_part_t re;
        sum_part_t im;
    } sum_cplx_t;

    typedef struct packed {
        out_part_t re;
        out_part_t im;
    } out_cplx_t;

endpackage
